//--- source/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and instruction word width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NUM_REGS 32

// bits needed to index one register
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// byte distance between consecutive instructions
`define RV_PC_STEP 4

`endif

//--- source/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_REG    = 7'b0110011,
		OPC_IMM    = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		// not executed, decoded as bubbles
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// operand source for the ALU
	typedef enum logic [1:0] {
		ALU_NONE = 2'd0,
		ALU_REG  = 2'd1,
		ALU_IMM  = 2'd2,
		ALU_LUI  = 2'd3
	} alu_op_e;

	// decode to execute
	typedef struct packed {
		logic                   valid;
		alu_op_e                op;
		logic [2:0]             funct3;
		// instr[30], picks sub and sra/srai
		logic                   alt;
		logic [`RV_REG_AW-1:0]  rs1;
		logic [`RV_REG_AW-1:0]  rs2;
		logic [`RV_REG_AW-1:0]  rd;
		logic [`RV_XLEN-1:0]    imm;
	} decoded_t;

	// write request into the register file, also the forwarding source
	typedef struct packed {
		logic                   valid;
		logic [`RV_REG_AW-1:0]  rd;
		logic [`RV_XLEN-1:0]    data;
	} wb_t;

endpackage

//--- source/fetch_unit.sv
`include "rv_macros.svh"

module fetch_unit (
	input  logic                clk,
	input  logic                reset,
	output logic [`RV_XLEN-1:0] o_pc_addr,
	output logic                o_pc_rd,
	input  logic [`RV_XLEN-1:0] i_pc_rddata,
	output logic [`RV_XLEN-1:0] o_instr,
	output logic                o_instr_valid
);

	// memory answers this cycle for last cycle's read
	logic fetch_pending;

	// pc and read strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			o_pc_rd   <= 1'b0;
			o_pc_addr <= `RV_RESET_PC;
		end else begin
			o_pc_rd <= 1'b1;
			if (o_pc_rd) begin
				o_pc_addr <= o_pc_addr + `RV_PC_STEP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_pending <= 1'b0;
			o_instr_valid <= 1'b0;
		end else begin
			fetch_pending <= o_pc_rd;
			o_instr_valid <= fetch_pending;
		end
	end

	// instruction register loads one cycle after the strobe
	always_ff @(posedge clk) begin
		if (fetch_pending) begin
			o_instr <= i_pc_rddata;
		end
	end

	// word aligned fetch address
	a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
		o_pc_addr[1:0] == 2'b00);

endmodule

//--- source/instr_decoder.sv
`include "rv_macros.svh"

module instr_decoder (
	input  logic                clk,
	input  logic                reset,
	input  logic [`RV_XLEN-1:0] i_instr,
	input  logic                i_instr_valid,
	output rv_pkg::decoded_t    o_dec
);

	rv_pkg::opcode_e  opcode;
	rv_pkg::alu_op_e  alu_op;
	rv_pkg::decoded_t dec_next;

	assign opcode = rv_pkg::opcode_e'(i_instr[6:0]);

	// pick the ALU operation from the major opcode
	always_comb begin
		case (opcode)
			rv_pkg::OPC_REG: alu_op = rv_pkg::ALU_REG;
			rv_pkg::OPC_IMM: alu_op = rv_pkg::ALU_IMM;
			rv_pkg::OPC_LUI: alu_op = rv_pkg::ALU_LUI;
			// memory, control flow and auipc are dropped
			rv_pkg::OPC_LOAD,
			rv_pkg::OPC_STORE,
			rv_pkg::OPC_BRANCH,
			rv_pkg::OPC_JAL,
			rv_pkg::OPC_JALR,
			rv_pkg::OPC_AUIPC: alu_op = rv_pkg::ALU_NONE;
			default: alu_op = rv_pkg::ALU_NONE;
		endcase
		// empty slot
		if (!i_instr_valid) begin
			alu_op = rv_pkg::ALU_NONE;
		end
	end

	// field extraction
	always_comb begin
		dec_next.op     = alu_op;
		dec_next.valid  = (alu_op != rv_pkg::ALU_NONE);
		dec_next.funct3 = i_instr[14:12];
		dec_next.alt    = i_instr[30];
		dec_next.rs1    = i_instr[19:15];
		dec_next.rs2    = i_instr[24:20];
		dec_next.rd     = i_instr[11:7];
		if (alu_op == rv_pkg::ALU_LUI) begin
			// u immediate
			dec_next.imm = {i_instr[31:12], 12'b0};
		end else begin
			// sign extended i immediate
			dec_next.imm = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
		end
	end

	// decoded instruction register
	always_ff @(posedge clk) begin
		o_dec <= dec_next;
		if (reset) begin
			o_dec.valid <= 1'b0;
		end
	end

endmodule

//--- source/execute_stage.sv
`include "rv_macros.svh"

module execute_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  rv_pkg::decoded_t      i_dec,
	output logic [`RV_REG_AW-1:0] o_rs1_addr,
	output logic [`RV_REG_AW-1:0] o_rs2_addr,
	input  logic [`RV_XLEN-1:0]   i_rs1_data,
	input  logic [`RV_XLEN-1:0]   i_rs2_data,
	output rv_pkg::wb_t           o_wb
);

	logic                fwd_rs1;
	logic                fwd_rs2;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]          shamt;
	logic                lt_signed;
	logic                lt_unsigned;
	logic                is_sub;
	logic [`RV_XLEN-1:0] result;

	assign o_rs1_addr = i_dec.rs1;
	assign o_rs2_addr = i_dec.rs2;

	// previous instruction sits in o_wb and is not yet in the file
	assign fwd_rs1 = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_dec.rs1);
	assign fwd_rs2 = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_dec.rs2);

	assign rs1_val = fwd_rs1 ? o_wb.data : i_rs1_data;
	assign rs2_val = fwd_rs2 ? o_wb.data : i_rs2_data;

	// second operand, register or immediate
	assign op_b  = (i_dec.op == rv_pkg::ALU_REG) ? rs2_val : i_dec.imm;
	assign shamt = op_b[4:0];

	assign lt_signed   = $signed(rs1_val) < $signed(op_b);
	assign lt_unsigned = rs1_val < op_b;

	// addi has no sub form, imm bit 10 is just data there
	assign is_sub = (i_dec.op == rv_pkg::ALU_REG) && i_dec.alt;

	always_comb begin
		case (i_dec.funct3)
			3'b000: result = is_sub ? (rs1_val - op_b) : (rs1_val + op_b);
			3'b001: result = rs1_val << shamt;
			3'b010: result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
			3'b011: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
			3'b100: result = rs1_val ^ op_b;
			// alt picks sra/srai over srl/srli
			3'b101: begin
				if (i_dec.alt) begin
					result = $signed(rs1_val) >>> shamt;
				end else begin
					result = rs1_val >> shamt;
				end
			end
			3'b110: result = rs1_val | op_b;
			default: result = rs1_val & op_b;
		endcase
		if (i_dec.op == rv_pkg::ALU_LUI) begin
			result = i_dec.imm;
		end
	end

	// write-back register, x0 targets drop out here
	always_ff @(posedge clk) begin
		o_wb.rd   <= i_dec.rd;
		o_wb.data <= result;
		if (reset) begin
			o_wb.valid <= 1'b0;
		end else begin
			o_wb.valid <= i_dec.valid && (i_dec.rd != '0);
		end
	end

	// the register file relies on this to keep x0 clean
	a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
		!(o_wb.valid && (o_wb.rd == '0)));

endmodule

//--- source/reg_file.sv
`include "rv_macros.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  rv_pkg::wb_t           i_wb,
	input  logic [`RV_REG_AW-1:0] i_rs1_addr,
	input  logic [`RV_REG_AW-1:0] i_rs2_addr,
	output logic [`RV_XLEN-1:0]   o_rs1_data,
	output logic [`RV_XLEN-1:0]   o_rs2_data,
	input  logic [`RV_REG_AW-1:0] i_dbg_addr,
	output logic [`RV_XLEN-1:0]   o_dbg_data
);

	logic [`RV_XLEN-1:0] regs [0:`RV_NUM_REGS-1];

	// x0 reads as zero on every port
	function automatic logic [`RV_XLEN-1:0] read_reg(input logic [`RV_REG_AW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.valid && (i_wb.rd != '0)) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	assign o_rs1_data = read_reg(i_rs1_addr);
	assign o_rs2_data = read_reg(i_rs2_addr);
	assign o_dbg_data = read_reg(i_dbg_addr);

	// storage for x0 never leaves zero
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		regs[0] == '0);

endmodule

//--- source/rv_core_top.sv
`include "rv_macros.svh"

module rv_core_top (
	input  logic                  clk,
	input  logic                  reset,
	output logic [`RV_XLEN-1:0]   o_pc_addr,
	output logic                  o_pc_rd,
	input  logic [`RV_XLEN-1:0]   i_pc_rddata,
	input  logic [`RV_REG_AW-1:0] i_dbg_addr,
	output logic [`RV_XLEN-1:0]   o_dbg_data
);

	logic [`RV_XLEN-1:0]   instr;
	logic                  instr_valid;
	rv_pkg::decoded_t      dec;
	logic [`RV_REG_AW-1:0] rs1_addr;
	logic [`RV_REG_AW-1:0] rs2_addr;
	logic [`RV_XLEN-1:0]   rs1_data;
	logic [`RV_XLEN-1:0]   rs2_data;
	rv_pkg::wb_t           wb;

	fetch_unit i_fetch_unit (
		.clk           (clk),
		.reset         (reset),
		.o_pc_addr     (o_pc_addr),
		.o_pc_rd       (o_pc_rd),
		.i_pc_rddata   (i_pc_rddata),
		.o_instr       (instr),
		.o_instr_valid (instr_valid)
	);

	instr_decoder i_instr_decoder (
		.clk           (clk),
		.reset         (reset),
		.i_instr       (instr),
		.i_instr_valid (instr_valid),
		.o_dec         (dec)
	);

	execute_stage i_execute_stage (
		.clk        (clk),
		.reset      (reset),
		.i_dec      (dec),
		.o_rs1_addr (rs1_addr),
		.o_rs2_addr (rs2_addr),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.o_wb       (wb)
	);

	// sits beside execute, written from its wb register
	reg_file i_reg_file (
		.clk        (clk),
		.reset      (reset),
		.i_wb       (wb),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.i_dbg_addr (i_dbg_addr),
		.o_dbg_data (o_dbg_data)
	);

endmodule

//--- tests/tb_rv_core.sv
`include "rv_macros.svh"

module tb_rv_core;

	localparam int DRIVE_DLY = 10;
	localparam int MEM_WORDS = 256;
	localparam int START_TIMEOUT = 16;
	// addi x0, x0, 0
	localparam logic [`RV_XLEN-1:0] NOP = 32'h0000_0013;

	logic                  clk;
	logic                  reset;
	logic [`RV_XLEN-1:0]   o_pc_addr;
	logic                  o_pc_rd;
	logic [`RV_XLEN-1:0]   i_pc_rddata;
	logic [`RV_REG_AW-1:0] i_dbg_addr;
	logic [`RV_XLEN-1:0]   o_dbg_data;

	logic [`RV_XLEN-1:0] imem [0:MEM_WORDS-1];
	logic [`RV_XLEN-1:0] ref_regs [0:`RV_NUM_REGS-1];
	logic [`RV_XLEN-1:0] prog [$];
	logic                req_rd;
	logic [`RV_XLEN-1:0] req_addr;
	integer              seed;
	int                  errors;
	int                  passes;
	logic                hung;

	rv_core_top i_rv_core_top (
		.clk         (clk),
		.reset       (reset),
		.o_pc_addr   (o_pc_addr),
		.o_pc_rd     (o_pc_rd),
		.i_pc_rddata (i_pc_rddata),
		.i_dbg_addr  (i_dbg_addr),
		.o_dbg_data  (o_dbg_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory sees the request in cycle N and answers during N+1
	initial begin
		req_rd = 1'b0;
		req_addr = '0;
		forever begin
			@(negedge clk);
			req_rd = o_pc_rd;
			req_addr = o_pc_addr;
		end
	end

	initial begin
		i_pc_rddata = NOP;
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			if (req_rd && (req_addr[`RV_XLEN-1:10] == '0)) begin
				i_pc_rddata = imem[req_addr[9:2]];
			end else begin
				i_pc_rddata = NOP;
			end
		end
	end

	function automatic logic [`RV_XLEN-1:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input rv_pkg::opcode_e opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [`RV_XLEN-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, rv_pkg::OPC_IMM};
	endfunction

	function automatic logic [`RV_XLEN-1:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input rv_pkg::opcode_e opc);
		return {imm, rd, opc};
	endfunction

	function automatic rv_pkg::alu_op_e op_class(input logic [6:0] opc);
		case (opc)
			rv_pkg::OPC_REG: return rv_pkg::ALU_REG;
			rv_pkg::OPC_IMM: return rv_pkg::ALU_IMM;
			rv_pkg::OPC_LUI: return rv_pkg::ALU_LUI;
			default: return rv_pkg::ALU_NONE;
		endcase
	endfunction

	// one instruction of the sequential ISA model
	function automatic rv_pkg::wb_t ref_result(input logic [`RV_XLEN-1:0] w);
		rv_pkg::wb_t         wb;
		rv_pkg::alu_op_e     cls;
		logic [`RV_XLEN-1:0] a;
		logic [`RV_XLEN-1:0] b;
		logic [4:0]          sh;
		cls = op_class(w[6:0]);
		a = ref_regs[w[19:15]];
		b = (cls == rv_pkg::ALU_REG) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		sh = b[4:0];
		wb.valid = (cls != rv_pkg::ALU_NONE) && (w[11:7] != '0);
		wb.rd = w[11:7];
		case (w[14:12])
			3'd0: wb.data = (cls == rv_pkg::ALU_REG && w[30]) ? a - b : a + b;
			3'd1: wb.data = a << sh;
			3'd2: wb.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: wb.data = (a < b) ? 32'd1 : 32'd0;
			3'd4: wb.data = a ^ b;
			3'd5: begin
				if (w[30]) begin
					wb.data = $signed(a) >>> sh;
				end else begin
					wb.data = a >> sh;
				end
			end
			3'd6: wb.data = a | b;
			default: wb.data = a & b;
		endcase
		if (cls == rv_pkg::ALU_LUI) begin
			wb.data = {w[31:12], 12'h000};
		end
		return wb;
	endfunction

	task automatic check_reg(input int idx, input logic [`RV_XLEN-1:0] got,
			input logic [`RV_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Error o_dbg_data x%0d: got 0x%h, expected 0x%h", idx, got, exp);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Error o_pc_addr: got 0x%h, expected 0x%h", got, exp);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic check_strobe(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error o_pc_rd: got 0x%h, expected 0x%h", got, exp);
			errors++;
		end else begin
			passes++;
		end
	endtask

	task automatic emit(input logic [`RV_XLEN-1:0] w);
		prog.push_back(w);
	endtask

	// lui plus addi with the upper part rounded for the signed low half
	task automatic load_const(input logic [4:0] rd, input logic [`RV_XLEN-1:0] v);
		logic [`RV_XLEN-1:0] t;
		t = v + 32'h800;
		emit(enc_u(t[31:12], rd, rv_pkg::OPC_LUI));
		emit(enc_i(v[11:0], rd, 3'd0, rd));
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#DRIVE_DLY reset = 1'b1;
		repeat (8) @(posedge clk);
		#DRIVE_DLY reset = 1'b0;
	endtask

	task automatic wait_fetch_start(output logic found);
		found = 1'b0;
		for (int n = 0; n < START_TIMEOUT && !found; n++) begin
			@(negedge clk);
			if (o_pc_rd) begin
				found = 1'b1;
			end
		end
		if (!found) begin
			$display("timeout: o_pc_rd never went high after reset");
			hung = 1'b1;
		end
	endtask

	task automatic check_all_regs();
		for (int r = 0; r < `RV_NUM_REGS; r++) begin
			@(posedge clk);
			#DRIVE_DLY i_dbg_addr = `RV_REG_AW'(r);
			@(negedge clk);
			check_reg(r, o_dbg_data, ref_regs[r]);
		end
	endtask

	// load, model, reset, run, compare every register
	task automatic run_program();
		logic        found;
		rv_pkg::wb_t wb;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = NOP;
		end
		for (int r = 0; r < `RV_NUM_REGS; r++) begin
			ref_regs[r] = '0;
		end
		foreach (prog[i]) begin
			imem[i] = prog[i];
			wb = ref_result(prog[i]);
			if (wb.valid) begin
				ref_regs[wb.rd] = wb.data;
			end
		end
		reset_dut();
		wait_fetch_start(found);
		if (found) begin
			repeat (prog.size() + 8) @(posedge clk);
			check_all_regs();
		end
	endtask

	task automatic report_test(input string name, input int start_err);
		$display("test %s finished with %0d errors", name, errors - start_err);
	endtask

	task automatic test_fetch_order();
		int   start_err;
		logic found;
		start_err = errors;
		prog.delete();
		run_program();
		reset_dut();
		@(negedge clk);
		check_strobe(o_pc_rd, 1'b0);
		check_pc(o_pc_addr, `RV_RESET_PC);
		wait_fetch_start(found);
		if (found) begin
			check_pc(o_pc_addr, `RV_RESET_PC);
			for (int k = 1; k <= 8; k++) begin
				@(negedge clk);
				check_strobe(o_pc_rd, 1'b1);
				check_pc(o_pc_addr, `RV_RESET_PC + k * `RV_PC_STEP);
			end
		end
		report_test("fetch_order", start_err);
	endtask

	task automatic test_reg_ops();
		int start_err;
		start_err = errors;
		prog.delete();
		// negative x1 and positive x2 make signed and unsigned compares differ
		load_const(5'd1, $random(seed) | 32'h8000_0000);
		load_const(5'd2, $random(seed) & 32'h7fff_ffff);
		for (int k = 0; k < 8; k++) begin
			emit(enc(7'h00, 5'd2, 5'd1, 3'(k), 5'(k + 3), rv_pkg::OPC_REG));
		end
		emit(enc(7'h20, 5'd2, 5'd1, 3'd0, 5'd11, rv_pkg::OPC_REG));
		emit(enc(7'h20, 5'd2, 5'd1, 3'd5, 5'd12, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd1, 5'd2, 3'd2, 5'd13, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd1, 5'd2, 3'd3, 5'd14, rv_pkg::OPC_REG));
		run_program();
		report_test("reg_ops", start_err);
	endtask

	task automatic test_imm_ops();
		int          start_err;
		logic [11:0] imm;
		start_err = errors;
		prog.delete();
		load_const(5'd1, $random(seed) | 32'h8000_0000);
		load_const(5'd2, $random(seed) & 32'h7fff_ffff);
		for (int k = 0; k < 8; k++) begin
			imm = 12'($random(seed));
			if (k == 1 || k == 5) begin
				imm[11:5] = 7'h00;
			end else if (k == 3 || k == 0) begin
				imm[11] = 1'b1;
			end
			emit(enc_i(imm, 5'd1, 3'(k), 5'(k + 3)));
			emit(enc_i(imm, 5'd2, 3'(k), 5'(k + 11)));
		end
		imm = {7'h20, 5'($random(seed))};
		emit(enc_i(imm, 5'd1, 3'd5, 5'd19));
		emit(enc_i(imm, 5'd2, 3'd5, 5'd20));
		emit(enc_u(20'($random(seed)), 5'd21, rv_pkg::OPC_LUI));
		run_program();
		report_test("imm_ops", start_err);
	endtask

	task automatic test_forwarding();
		int start_err;
		start_err = errors;
		prog.delete();
		load_const(5'd1, $random(seed));
		emit(enc(7'h00, 5'd1, 5'd1, 3'd0, 5'd2, rv_pkg::OPC_REG));
		emit(enc_i(12'h005, 5'd2, 3'd0, 5'd3));
		emit(enc(7'h20, 5'd2, 5'd3, 3'd0, 5'd4, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd3, 5'd4, 3'd4, 5'd5, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd5, 5'd5, 3'd6, 5'd6, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd4, 5'd6, 3'd1, 5'd7, rv_pkg::OPC_REG));
		emit(NOP);
		emit(enc(7'h00, 5'd6, 5'd7, 3'd0, 5'd8, rv_pkg::OPC_REG));
		// back to back updates of the same register
		emit(enc_i(12'h001, 5'd8, 3'd0, 5'd8));
		emit(enc_i(12'hfff, 5'd8, 3'd0, 5'd8));
		emit(enc(7'h20, 5'd3, 5'd8, 3'd5, 5'd9, rv_pkg::OPC_REG));
		run_program();
		report_test("forwarding", start_err);
	endtask

	task automatic test_x0_bubbles();
		int start_err;
		start_err = errors;
		prog.delete();
		for (int r = 1; r <= 10; r++) begin
			load_const(5'(r), $random(seed));
		end
		// x0 writes each followed by a reader of x0
		emit(enc_i(12'h07b, 5'd1, 3'd0, 5'd0));
		emit(enc(7'h00, 5'd1, 5'd0, 3'd0, 5'd2, rv_pkg::OPC_REG));
		emit(enc_u(20'hfffff, 5'd0, rv_pkg::OPC_LUI));
		emit(enc(7'h00, 5'd0, 5'd0, 3'd6, 5'd3, rv_pkg::OPC_REG));
		emit(enc(7'h00, 5'd1, 5'd0, 3'd0, 5'd4, rv_pkg::OPC_REG));
		// dropped opcodes with rd fields pointing at live registers
		emit(enc(7'h00, 5'd1, 5'd2, 3'd2, 5'd5, rv_pkg::OPC_STORE));
		emit(enc(7'h00, 5'd1, 5'd1, 3'd0, 5'd6, rv_pkg::OPC_BRANCH));
		emit(enc(7'h00, 5'd0, 5'd1, 3'd2, 5'd7, rv_pkg::OPC_LOAD));
		emit(enc_u(20'h12345, 5'd8, rv_pkg::OPC_JAL));
		emit(enc_u(20'h00001, 5'd9, rv_pkg::OPC_AUIPC));
		emit(enc(7'h00, 5'd0, 5'd1, 3'd0, 5'd10, rv_pkg::OPC_JALR));
		emit(enc(7'h00, 5'd5, 5'd5, 3'd0, 5'd11, rv_pkg::OPC_REG));
		run_program();
		report_test("x0_bubbles", start_err);
	endtask

	initial begin
		reset = 1'b1;
		i_dbg_addr = '0;
		seed = 32'hd859;
		errors = 0;
		passes = 0;
		hung = 1'b0;
		test_fetch_order();
		if (!hung) begin
			test_reg_ops();
		end
		if (!hung) begin
			test_imm_ops();
		end
		if (!hung) begin
			test_forwarding();
		end
		if (!hung) begin
			test_x0_bubbles();
		end
		$display("checks passed: %0d, errors: %0d", passes, errors);
		if (errors == 0 && !hung) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/rv_pkg.sv
source/fetch_unit.sv
source/instr_decoder.sv
source/execute_stage.sv
source/reg_file.sv
source/rv_core_top.sv
tests/tb_rv_core.sv

//--- Makefile
TOP = tb_rv_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | awk '{ print } /Simulation finished: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
